/* lc3b_apb_core.f */
design/lc3b_types.sv
design/lc3b_apb_pkg.sv
design/lc3b_pipe_if.sv
design/control_rom.sv
design/lc3b_decode.sv
design/lc3b_regfile.sv
design/lc3b_execute.sv
design/lc3b_apb_port.sv
design/lc3b_apb_core.sv
sim/tb_lc3b_apb_core.sv

/* Bender.yml */
package:
  name: lc3b_apb_core

sources:
  # packages and interfaces ahead of the modules that import them
  - files:
      - design/lc3b_types.sv
      - design/lc3b_apb_pkg.sv
      - design/lc3b_pipe_if.sv
      - design/control_rom.sv
      - design/lc3b_decode.sv
      - design/lc3b_regfile.sv
      - design/lc3b_execute.sv
      - design/lc3b_apb_port.sv
      - design/lc3b_apb_core.sv
  - target: simulation
    files:
      - sim/tb_lc3b_apb_core.sv

/* sim/tb_lc3b_apb_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lc3b_apb_core import lc3b_apb_pkg::*; ();

    localparam int CLK_PERIOD      = 10;
    localparam int SETTLE          = 1;     // sample point after the falling edge
    localparam int SEED            = 10861;
    localparam int XFER_BUDGET     = 2000;  // upper bound on apb transfers below
    localparam int WATCHDOG_CYCLES = XFER_BUDGET * 20 + 1000;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // reference state
    logic [15:0] m_regs [8];
    logic [15:0] m_pc;
    logic [2:0]  m_cc;
    int          errors;

    lc3b_apb_core dut0 (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // a read may only finish once the last pushed instruction has retired
    a_read_after_push: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && pwrite && pready && !pslverr)
            |=> !(psel && penable && !pwrite && pready))
        else abort_run("a read completed while an instruction was still in flight");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    // hold the access phase until pready, sampled after the falling edge
    task automatic wait_ready(output logic [31:0] rdata, output logic err);
        logic got;
        begin
            got = 1'b0;
            while (!got) begin
                #(SETTLE);
                if (pready) begin
                    got   = 1'b1;
                    rdata = prdata;
                    err   = pslverr;
                end
                @(posedge clk);
                if (!got)
                    @(negedge clk);
            end
        end
    endtask

    // one transfer, setup then access until pready
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        begin
            @(negedge clk);
            psel    = 1'b1;
            penable = 1'b0;
            pwrite  = wr;
            paddr   = addr;
            pwdata  = wdata;
            @(negedge clk);
            penable = 1'b1;
            wait_ready(rdata, err);
        end
    endtask

    task automatic apb_idle();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic model_exec(input logic [15:0] ir);
        logic [15:0] sr1v;
        logic [15:0] opb;
        logic [15:0] pc2;
        logic [15:0] off9;
        logic [15:0] res;
        logic [15:0] next_pc;
        logic [2:0]  dst;
        logic        wr;
        logic        set_cc;
        begin
            sr1v    = m_regs[ir[8:6]];
            opb     = ir[5] ? {{11{ir[4]}}, ir[4:0]} : m_regs[ir[2:0]];
            pc2     = m_pc + 16'd2;
            off9    = {{6{ir[8]}}, ir[8:0], 1'b0};
            next_pc = pc2;
            res     = 16'h0000;
            dst     = ir[11:9];
            case (ir[15:12])
                4'b0001: res = sr1v + opb;
                4'b0101: res = sr1v & opb;
                4'b1001: res = ~sr1v;
                4'b1101: begin
                    if (!ir[4])
                        res = sr1v << ir[3:0];
                    else if (!ir[5])
                        res = sr1v >> ir[3:0];
                    else
                        res = $signed(sr1v) >>> ir[3:0];
                end
                4'b1110: res = pc2 + off9;
                4'b0000: begin
                    if ((ir[11:9] & m_cc) != 3'b000)
                        next_pc = pc2 + off9;
                end
                4'b1100: next_pc = sr1v;
                4'b0100: begin
                    res     = pc2;  // link
                    dst     = 3'd7;
                    next_pc = ir[11] ? pc2 + {{4{ir[10]}}, ir[10:0], 1'b0} : sr1v;
                end
                default: res = 16'h0000;  // unsupported, pc only
            endcase
            case (ir[15:12])
                4'b0001, 4'b0101, 4'b1001, 4'b1101, 4'b1110: set_cc = 1'b1;
                default: set_cc = 1'b0;
            endcase
            wr = set_cc || (ir[15:12] == 4'b0100);
            if (wr)
                m_regs[dst] = res;
            if (set_cc)
                m_cc = res[15] ? 3'b100 : ((res == 16'h0000) ? 3'b010 : 3'b001);
            m_pc = next_pc;
        end
    endtask

    task automatic issue(input logic [15:0] ir);
        logic [31:0] rd;
        logic        err;
        begin
            apb_xfer(1'b1, ADDR_INSTR, {16'h0000, ir}, rd, err);
            a_push_ok: assert (!err)
                else abort_run($sformatf("instruction write 0x%04h got pslverr", ir));
            model_exec(ir);
        end
    endtask

    // read access with no setup cycle right behind a push, so it meets the busy stall
    task automatic read_behind_push(input logic [15:0] ir);
        logic [31:0] rd;
        logic        err;
        logic [2:0]  r;
        begin
            r = ir[11:9];
            issue(ir);
            @(negedge clk);
            pwrite = 1'b0;
            paddr  = ADDR_REG_BASE + {3'b000, r, 2'b00};
            wait_ready(rd, err);
            a_stall_err: assert (!err)
                else abort_run("unexpected pslverr on a read right behind a push");
            a_stall_val: assert (rd == {16'h0000, m_regs[r]})
                else abort_run($sformatf("ERR @ %0t: R%0d read behind a push 0x%08h, expected 0x%08h",
                                         $time, r, rd, {16'h0000, m_regs[r]}));
        end
    endtask

    // and #0, then four shift-and-add nibble steps
    task automatic load_reg(input logic [2:0] r, input logic [15:0] value);
        issue({4'b0101, r, r, 1'b1, 5'b00000});
        for (int k = 3; k >= 0; k--) begin
            issue({4'b1101, r, r, 2'b00, 4'd4});
            issue({4'b0001, r, r, 2'b10, value[4*k +: 4]});
        end
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [15:0] exp,
                              input string what);
        logic [31:0] rd;
        logic        err;
        begin
            apb_xfer(1'b0, addr, 32'h0, rd, err);
            a_read_ok: assert (!err)
                else abort_run($sformatf("unexpected pslverr on read of %s", what));
            a_read_val: assert (rd == {16'h0000, exp})
                else abort_run($sformatf("ERR @ %0t: %s read 0x%08h, expected 0x%08h",
                                         $time, what, rd, {16'h0000, exp}));
        end
    endtask

    task automatic check_state();
        logic [7:0] addr;
        begin
            read_check(ADDR_STATUS, {13'h0000, m_cc}, "STATUS");
            read_check(ADDR_PC, m_pc, "PC");
            addr = ADDR_REG_BASE;
            for (int i = 0; i < 8; i++) begin
                read_check(addr, m_regs[i], $sformatf("R%0d", i));
                addr = addr + 8'd4;
            end
        end
    endtask

    task automatic expect_error(input logic wr, input logic [7:0] addr);
        logic [31:0] rd;
        logic        err;
        begin
            apb_xfer(wr, addr, 32'h0000_1021, rd, err);  // add r0 if it ever executed
            a_bad_access: assert (err)
                else abort_run($sformatf("no pslverr on %s at address 0x%02h",
                                         wr ? "write" : "read", addr));
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [15:0] val;
        logic [3:0]  bad_ops [3];
        void'($urandom(SEED));
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        errors  = 0;
        m_pc    = 16'h0000;
        m_cc    = 3'b000;
        foreach (m_regs[i])
            m_regs[i] = 16'h0000;
        bad_ops[0] = 4'b0110;  // ldr
        bad_ops[1] = 4'b0111;  // str
        bad_ops[2] = 4'b1111;  // trap
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #(SETTLE);
        a_idle_bus: assert (!pready && !pslverr)
            else abort_run("pready or pslverr high on an idle bus after reset");

        check_state();

        // alu ops on random operands, dependent pair first
        for (int r = 0; r < 8; r++) begin
            rnd = $urandom;
            load_reg(r[2:0], rnd[15:0]);
        end
        issue({4'b0001, 3'd1, 3'd0, 2'b10, 4'd5});
        issue({4'b0001, 3'd2, 3'd1, 3'b000, 3'd1});
        check_state();
        for (int n = 0; n < 40; n++) begin
            rnd = $urandom;
            case (rnd[31:29] % 5)
                0: issue({4'b0001, rnd[2:0], rnd[5:3], 3'b000, rnd[8:6]});
                1: issue({4'b0001, rnd[2:0], rnd[5:3], 1'b1, rnd[13:9]});
                2: issue({4'b0101, rnd[2:0], rnd[5:3], 3'b000, rnd[8:6]});
                3: issue({4'b0101, rnd[2:0], rnd[5:3], 1'b1, rnd[13:9]});
                default: issue({4'b1001, rnd[2:0], rnd[5:3], 6'b111111});
            endcase
            if (n % 8 == 7)
                check_state();
        end

        // reads straight behind a push have to stall
        for (int s = 0; s < 4; s++) begin
            rnd = $urandom;
            read_behind_push({4'b0001, rnd[2:0], rnd[5:3], 1'b1, rnd[13:9]});
        end

        // sll, srl, sra
        for (int m = 0; m < 3; m++) begin
            repeat (6) begin
                rnd = $urandom;
                val = rnd[15:0];
                if (m == 2)
                    val[15] = 1'b1;  // negative operand for sra
                load_reg(rnd[18:16], val);
                issue({4'b1101, rnd[21:19], rnd[18:16], (m == 0) ? 2'b00 : {m == 2, 1'b1},
                       rnd[25:22]});
                check_state();
            end
        end

        // every nzp mask against n, z and p
        for (int c = 0; c < 3; c++) begin
            for (int mask = 0; mask < 8; mask++) begin
                issue({4'b0101, 3'd0, 3'd0, 1'b1, 5'b00000});
                if (c == 0)
                    issue({4'b1001, 3'd0, 3'd0, 6'b111111});
                else if (c == 2)
                    issue({4'b0001, 3'd0, 3'd0, 1'b1, 5'd1});
                rnd = $urandom;
                issue({4'b0000, mask[2:0], rnd[8:0]});
                read_check(ADDR_PC, m_pc, "PC");
                read_check(ADDR_STATUS, {13'h0000, m_cc}, "STATUS");
            end
        end
        repeat (6) begin
            rnd = $urandom;
            issue({4'b1110, rnd[11:9], rnd[8:0]});
            check_state();
        end

        // jmp, jsr, jsrr
        repeat (4) begin
            rnd = $urandom;
            load_reg(rnd[18:16], rnd[15:0]);
            issue({4'b1100, 3'b000, rnd[18:16], 6'b000000});
            read_check(ADDR_PC, m_pc, "PC");
            issue({4'b0100, 1'b1, rnd[29:19]});
            check_state();
            issue({4'b0100, 3'b000, rnd[18:16], 6'b000000});
            check_state();
        end
        issue({4'b0100, 3'b000, 3'd7, 6'b000000});  // jsrr through r7 itself
        check_state();

        // unsupported opcodes only move pc
        for (int b = 0; b < 3; b++) begin
            rnd = $urandom;
            issue({bad_ops[b], rnd[11:0]});
            check_state();
        end

        expect_error(1'b1, ADDR_STATUS);
        expect_error(1'b1, ADDR_PC);
        expect_error(1'b1, ADDR_REG_BASE + 8'd4);
        expect_error(1'b1, 8'h10);
        expect_error(1'b0, ADDR_INSTR);
        expect_error(1'b0, 8'h0C);
        expect_error(1'b0, ADDR_REG_BASE + 8'd2);  // misaligned
        expect_error(1'b0, 8'h40);
        check_state();

        apb_idle();
        repeat (2) @(posedge clk);
        if (errors == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("errors were recorded during the run");
        end
    end

endmodule : tb_lc3b_apb_core

`default_nettype wire

/* design/lc3b_apb_core.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_apb_core import lc3b_types::*, lc3b_apb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic       instr_push;
    lc3b_word   instr;
    lc3b_reg    dbg_sel;
    lc3b_word   dbg_data;
    lc3b_word   pc;
    logic [2:0] cc;

    id_ex_if    pipe ();
    reg_port_if rport ();

    lc3b_apb_port port0 (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (pipe.valid),  // decode register is the only in-flight slot
        .pc         (pc),
        .cc         (cc),
        .dbg_data   (dbg_data),
        .dbg_sel    (dbg_sel),
        .instr_push (instr_push),
        .instr      (instr)
    );

    lc3b_decode decode0 (
        .clk        (clk),
        .rst        (rst),
        .instr_push (instr_push),
        .instr      (instr),
        .id_ex      (pipe.producer)
    );

    lc3b_regfile regfile0 (
        .clk      (clk),
        .rst      (rst),
        .rp       (rport.regfile),
        .dbg_sel  (dbg_sel),
        .dbg_data (dbg_data)
    );

    lc3b_execute execute0 (
        .clk   (clk),
        .rst   (rst),
        .id_ex (pipe.consumer),
        .rp    (rport.execute),
        .pc    (pc),
        .cc    (cc)
    );

endmodule : lc3b_apb_core

`default_nettype wire

/* design/lc3b_apb_port.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_apb_port import lc3b_types::*, lc3b_apb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  busy,
    input  lc3b_word              pc,
    input  logic [2:0]            cc,
    input  lc3b_word              dbg_data,
    output lc3b_reg               dbg_sel,
    output logic                  instr_push,
    output lc3b_word              instr
);

    logic [APB_ADDR_W-1:0] reg_off;
    logic                  hit_instr;
    logic                  hit_status;
    logic                  hit_pc;
    logic                  hit_reg;
    logic                  bad;

    assign reg_off    = paddr - ADDR_REG_BASE;
    assign hit_instr  = (paddr == ADDR_INSTR);
    assign hit_status = (paddr == ADDR_STATUS);
    assign hit_pc     = (paddr == ADDR_PC);
    assign hit_reg    = (paddr >= ADDR_REG_BASE) && (reg_off[1:0] == 2'b00) &&
                        (reg_off < APB_ADDR_W'(NUM_REGS * REG_STRIDE));
    assign dbg_sel    = lc3b_reg'(reg_off >> $clog2(REG_STRIDE));

    assign bad = pwrite ? !hit_instr : !(hit_status || hit_pc || hit_reg);

    // reads wait until both stages drain
    assign pready     = psel && penable && (pwrite || !busy);
    assign pslverr    = pready && bad;
    assign instr_push = pready && pwrite && !bad;
    assign instr      = pwdata[15:0];

    always_comb begin
        if (hit_status)
            prdata = APB_DATA_W'(cc);
        else if (hit_pc)
            prdata = APB_DATA_W'(pc);
        else if (hit_reg)
            prdata = APB_DATA_W'(dbg_data);
        else
            prdata = '0;
    end

    // host must hold a stalled transfer
    a_wait_hold: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && !pready) |=> (psel && penable && $stable(paddr) && $stable(pwrite)))
        else $error("apb port: transfer dropped during wait state");

endmodule : lc3b_apb_port

`default_nettype wire

/* design/lc3b_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_execute import lc3b_types::*; (
    input  logic        clk,
    input  logic        rst,
    id_ex_if.consumer   id_ex,
    reg_port_if.execute rp,
    output lc3b_word    pc,
    output logic [2:0]  cc
);

    lc3b_control_word ctrl;
    lc3b_word         ir;
    lc3b_word         alu_b;
    lc3b_word         alu_out;
    lc3b_word         pc_plus2;
    lc3b_word         pc_offset;
    lc3b_word         pcn;
    lc3b_word         pc_next;
    lc3b_word         cc_data;
    logic [2:0]       cc_next;
    logic             br_taken;

    assign ir   = id_ex.ir;
    assign ctrl = id_ex.ctrl;

    assign rp.sr1 = ir[8:6];  // sr1 and baser share a field
    assign rp.sr2 = ir[2:0];

    always_comb begin
        case (ctrl.general_alu_mux_sel)
            lc3b_general_alu_mux_sel_imm5: alu_b = {{11{ir[4]}}, ir[4:0]};
            lc3b_general_alu_mux_sel_imm4: alu_b = {12'b0, ir[3:0]};
            default:                       alu_b = rp.rdata2;
        endcase

        case (ctrl.general_alu_op)
            lc3b_alu_op_add: alu_out = rp.rdata1 + alu_b;
            lc3b_alu_op_and: alu_out = rp.rdata1 & alu_b;
            lc3b_alu_op_not: alu_out = ~rp.rdata1;
            lc3b_alu_op_sll: alu_out = rp.rdata1 << alu_b[3:0];
            lc3b_alu_op_srl: alu_out = rp.rdata1 >> alu_b[3:0];
            lc3b_alu_op_sra: alu_out = lc3b_word'($signed(rp.rdata1) >>> alu_b[3:0]);
            default:         alu_out = rp.rdata1;  // pass
        endcase
    end

    assign pc_plus2  = pc + 16'd2;
    assign pc_offset = (ctrl.pc_adder_mux_sel == lc3b_pc_adder_mux_sel_offset11) ?
                       {{4{ir[10]}}, ir[10:0], 1'b0} : {{6{ir[8]}}, ir[8:0], 1'b0};
    assign pcn       = pc_plus2 + pc_offset;
    assign br_taken  = |(ir[11:9] & cc);  // nzp mask against current cc

    always_comb begin
        case (ctrl.pc_mux_sel)
            lc3b_pc_mux_sel_pcn: pc_next = pcn;
            lc3b_pc_mux_sel_alu: pc_next = alu_out;
            default:             pc_next = pc_plus2;
        endcase
        if (ctrl.conditional_branch && !br_taken)
            pc_next = pc_plus2;

        case (ctrl.regfile_data_mux_sel)
            lc3b_regfile_data_mux_sel_pcn: rp.wdata = pcn;
            lc3b_regfile_data_mux_sel_pc:  rp.wdata = pc_plus2;  // link address
            default:                       rp.wdata = alu_out;
        endcase
    end

    assign cc_data = (ctrl.cc_gen_mux_sel == lc3b_cc_gen_mux_sel_pcn) ? pcn : alu_out;
    assign cc_next = cc_data[15] ? 3'b100 : ((cc_data == '0) ? 3'b010 : 3'b001);

    assign rp.dest = (ctrl.regfile_dest_mux_sel == lc3b_regfile_dest_mux_sel_r7) ?
                     3'd7 : ir[11:9];
    assign rp.load = id_ex.valid & ctrl.regfile_load;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            cc <= '0;
        end else if (id_ex.valid) begin
            pc <= pc_next;
            if (ctrl.cc_load)
                cc <= cc_next;
        end
    end

    // decode must flush the control word between pushes
    a_load_valid: assert property (@(posedge clk) disable iff (rst)
        id_ex.ctrl.regfile_load |-> id_ex.valid)
        else $error("execute: regfile_load without a valid instruction");

endmodule : lc3b_execute

`default_nettype wire

/* design/lc3b_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_regfile import lc3b_types::*; (
    input  logic       clk,
    input  logic       rst,
    reg_port_if.regfile rp,
    input  lc3b_reg    dbg_sel,
    output lc3b_word   dbg_data
);

    lc3b_word regs [2**$bits(lc3b_reg)];

    always_ff @(posedge clk) begin
        if (rst) begin
            foreach (regs[i])
                regs[i] <= '0;
        end else if (rp.load) begin
            regs[rp.dest] <= rp.wdata;
        end
    end

    // reads see last cycle's write
    assign rp.rdata1 = regs[rp.sr1];
    assign rp.rdata2 = regs[rp.sr2];
    assign dbg_data  = regs[dbg_sel];  // apb readback

    a_load_known: assert property (@(posedge clk) disable iff (rst)
        rp.load |-> !$isunknown({rp.dest, rp.wdata}))
        else $error("regfile: write with unknown dest or data");

endmodule : lc3b_regfile

`default_nettype wire

/* design/lc3b_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module lc3b_decode import lc3b_types::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_push,
    input  lc3b_word  instr,
    id_ex_if.producer id_ex
);

    lc3b_control_word rom_ctrl;

    control_rom rom0 (
        .ir_in       (instr),
        .control_out (rom_ctrl)
    );

    // valid lasts one cycle per push
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else begin
            id_ex.valid <= instr_push;
            if (instr_push)
                id_ex.ctrl <= rom_ctrl;
            else
                id_ex.ctrl <= '0;  // idle slot carries a no-op word
        end
    end

    always_ff @(posedge clk) begin
        if (instr_push) begin
            id_ex.ir <= instr;
        end
    end

endmodule : lc3b_decode

`default_nettype wire

/* design/control_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module control_rom import lc3b_types::*; (
    input  lc3b_word         ir_in,
    output lc3b_control_word control_out
);

    lc3b_opcode opcode;

    assign opcode = lc3b_opcode'(ir_in[15:12]);

    always_comb begin
        control_out = '0;  // default is a plain pc+2

        case (opcode)
            op_add, op_and: begin
                if (ir_in[5])
                    control_out.general_alu_mux_sel = lc3b_general_alu_mux_sel_imm5;
                else
                    control_out.general_alu_mux_sel = lc3b_general_alu_mux_sel_sr2;
                if (opcode == op_add)
                    control_out.general_alu_op = lc3b_alu_op_add;
                else
                    control_out.general_alu_op = lc3b_alu_op_and;
                control_out.cc_load = 1'b1;
                control_out.cc_gen_mux_sel = lc3b_cc_gen_mux_sel_alu;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_alu;
                control_out.regfile_load = 1'b1;
            end

            op_not: begin
                control_out.general_alu_op = lc3b_alu_op_not;
                control_out.cc_load = 1'b1;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_alu;
                control_out.regfile_load = 1'b1;
            end

            op_shf: begin
                control_out.general_alu_mux_sel = lc3b_general_alu_mux_sel_imm4;
                if (!ir_in[4])
                    control_out.general_alu_op = lc3b_alu_op_sll;
                else if (!ir_in[5])
                    control_out.general_alu_op = lc3b_alu_op_srl;
                else
                    control_out.general_alu_op = lc3b_alu_op_sra;
                control_out.cc_load = 1'b1;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_alu;
                control_out.regfile_load = 1'b1;
            end

            op_lea: begin
                control_out.pc_adder_mux_sel = lc3b_pc_adder_mux_sel_offset9;
                control_out.cc_load = 1'b1;
                control_out.cc_gen_mux_sel = lc3b_cc_gen_mux_sel_pcn;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_pcn;
                control_out.regfile_dest_mux_sel = lc3b_regfile_dest_mux_sel_dest;
                control_out.regfile_load = 1'b1;
            end

            op_br: begin
                control_out.conditional_branch = 1'b1;  // taken only on nzp match
                control_out.pc_mux_sel = lc3b_pc_mux_sel_pcn;
                control_out.pc_adder_mux_sel = lc3b_pc_adder_mux_sel_offset9;
            end

            op_jmp: begin
                control_out.pc_mux_sel = lc3b_pc_mux_sel_alu;  // baser via pass
                control_out.general_alu_op = lc3b_alu_op_pass;
            end

            op_jsr: begin
                if (ir_in[11])
                    control_out.pc_mux_sel = lc3b_pc_mux_sel_pcn;
                else
                    control_out.pc_mux_sel = lc3b_pc_mux_sel_alu;  // jsrr
                control_out.pc_adder_mux_sel = lc3b_pc_adder_mux_sel_offset11;
                control_out.general_alu_op = lc3b_alu_op_pass;
                control_out.regfile_data_mux_sel = lc3b_regfile_data_mux_sel_pc;
                control_out.regfile_dest_mux_sel = lc3b_regfile_dest_mux_sel_r7;
                control_out.regfile_load = 1'b1;
            end

            default: ;  // loads, stores, trap, rti
        endcase
    end

    // opcodes outside the kept set decode to the zero word
    a_unsup_zero: assert final (!(opcode inside {op_ldb, op_stb, op_ldr, op_str, op_rti,
                                                  op_ldi, op_sti, op_trap})
                                || control_out == '0)
        else $error("control_rom: nonzero control word for opcode %b", ir_in[15:12]);

endmodule : control_rom

`default_nettype wire

/* design/lc3b_pipe_if.sv */
`timescale 1ns/1ns
`default_nettype none

// decode register to execute stage
interface id_ex_if import lc3b_types::*; ();
    logic             valid;
    lc3b_word         ir;
    lc3b_control_word ctrl;

    modport producer (
        output valid,
        output ir,
        output ctrl
    );

    modport consumer (
        input valid,
        input ir,
        input ctrl
    );
endinterface : id_ex_if

interface reg_port_if import lc3b_types::*; ();
    lc3b_reg  sr1;
    lc3b_reg  sr2;
    logic     load;
    lc3b_reg  dest;
    lc3b_word wdata;
    lc3b_word rdata1;
    lc3b_word rdata2;

    modport execute (
        output sr1,
        output sr2,
        output load,
        output dest,
        output wdata,
        input  rdata1,
        input  rdata2
    );

    modport regfile (
        input  sr1,
        input  sr2,
        input  load,
        input  dest,
        input  wdata,
        output rdata1,
        output rdata2
    );
endinterface : reg_port_if

`default_nettype wire

/* design/lc3b_apb_pkg.sv */
`default_nettype none

package lc3b_apb_pkg;

    localparam int unsigned APB_ADDR_W = 8;
    localparam int unsigned APB_DATA_W = 32;

    localparam logic [APB_ADDR_W-1:0] ADDR_INSTR    = 8'h00;  // write only
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS   = 8'h04;  // n z p in bits 2..0
    localparam logic [APB_ADDR_W-1:0] ADDR_PC       = 8'h08;
    localparam logic [APB_ADDR_W-1:0] ADDR_REG_BASE = 8'h20;  // r0 .. r7

    localparam int unsigned NUM_REGS   = 8;
    localparam int unsigned REG_STRIDE = 4;

endpackage : lc3b_apb_pkg

`default_nettype wire

/* design/lc3b_types.sv */
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        lc3b_alu_op_pass,  // sr1 straight through
        lc3b_alu_op_add,
        lc3b_alu_op_and,
        lc3b_alu_op_not,
        lc3b_alu_op_sll,
        lc3b_alu_op_srl,
        lc3b_alu_op_sra
    } lc3b_alu_op;

    typedef enum logic [1:0] {
        lc3b_pc_mux_sel_pc_plus2,
        lc3b_pc_mux_sel_pcn,  // pc-relative target
        lc3b_pc_mux_sel_alu   // register target
    } lc3b_pc_mux_sel;

    typedef enum logic {
        lc3b_pc_adder_mux_sel_offset9,
        lc3b_pc_adder_mux_sel_offset11
    } lc3b_pc_adder_mux_sel;

    typedef enum logic [1:0] {
        lc3b_general_alu_mux_sel_sr2,
        lc3b_general_alu_mux_sel_imm5,
        lc3b_general_alu_mux_sel_imm4
    } lc3b_general_alu_mux_sel;

    typedef enum logic {
        lc3b_cc_gen_mux_sel_alu,
        lc3b_cc_gen_mux_sel_pcn
    } lc3b_cc_gen_mux_sel;

    typedef enum logic [1:0] {
        lc3b_regfile_data_mux_sel_alu,
        lc3b_regfile_data_mux_sel_pcn,
        lc3b_regfile_data_mux_sel_pc  // return address, pc+2
    } lc3b_regfile_data_mux_sel;

    typedef enum logic {
        lc3b_regfile_dest_mux_sel_dest,
        lc3b_regfile_dest_mux_sel_r7
    } lc3b_regfile_dest_mux_sel;

    // all-zero word: pc+2 and nothing else
    typedef struct packed {
        logic                     conditional_branch;
        lc3b_pc_mux_sel           pc_mux_sel;
        lc3b_pc_adder_mux_sel     pc_adder_mux_sel;
        lc3b_general_alu_mux_sel  general_alu_mux_sel;
        lc3b_alu_op               general_alu_op;
        logic                     cc_load;
        lc3b_cc_gen_mux_sel       cc_gen_mux_sel;
        lc3b_regfile_data_mux_sel regfile_data_mux_sel;
        lc3b_regfile_dest_mux_sel regfile_dest_mux_sel;
        logic                     regfile_load;
    } lc3b_control_word;

endpackage : lc3b_types

`default_nettype wire
